// File: motor_bridge_top.f
source/motor_bridge_pkg.sv
source/spi_byte_port.sv
source/frame_buffer.sv
source/param_sequencer.sv
source/bus_decoder.sv
source/motor_channel.sv
source/readback_mux.sv
source/motor_bridge_top.sv
tests/motor_bridge_asserts.sv
tests/tb_checker.sv
tests/tb_motor_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the motor bridge testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f motor_bridge_top.f \
  --top-module tb_motor_bridge \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// File: tests/tb_motor_bridge.sv
// testbench top for the motor bridge, sends LFSR frames over SPI while tb_checker compares replies
`timescale 1ns/10ps
module tb_motor_bridge;
  import motor_bridge_pkg::*;

  localparam int HALF_SCK      = 8;
  localparam int RESET_CYCLES  = 10;
  localparam int BUSY_RISE_MAX = 64;
  localparam int BUSY_FALL_MAX = 4000;
  localparam int SHORT_BYTES   = 20;
  localparam int LONG_BYTES    = 84;

  logic        wCLK24 = 1'b0;
  logic        rst_n;
  logic        sck;
  logic        ss_n;
  logic        mosi;
  logic        miso;
  logic        busy;
  logic [15:0] lfsr_state;
  string       test_name;
  int          chk_checks;
  int          chk_errors;
  int          tb_errors;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;

  always #10 wCLK24 = ~wCLK24;

  motor_bridge_top i_dut (
    .wCLK24  (wCLK24),
    .rst_n_i (rst_n),
    .sck_i   (sck),
    .ss_n_i  (ss_n),
    .mosi_i  (mosi),
    .miso_o  (miso),
    .busy_o  (busy)
  );

  tb_checker i_chk (
    .sck_i       (sck),
    .ss_n_i      (ss_n),
    .mosi_i      (mosi),
    .miso_i      (miso),
    .test_name_i (test_name),
    .checks_o    (chk_checks),
    .errors_o    (chk_errors)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_random_byte(output logic [7:0] b);
    b = 8'h00;
    repeat (8) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s: %s", test_name, reason);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      tb_errors++;
      $display("[FAIL] %s: %s expected %b actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic wait_busy_high();
    int n;
    n = 0;
    while (busy !== 1'b1) begin
      if (n == BUSY_RISE_MAX) begin
        abort_run("busy_o did not rise after the frame ended");
      end
      @(negedge wCLK24);
      n++;
    end
  endtask

  task automatic wait_busy_low();
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      if (n == BUSY_FALL_MAX) begin
        abort_run("busy_o stayed high, the register updates never finished");
      end
      @(negedge wCLK24);
      n++;
    end
  endtask

  // mode 0, msb first, data changes while sck is low
  task automatic shift_byte(input logic [7:0] b);
    logic [7:0] sr;
    sr = b;
    repeat (8) begin
      mosi = sr[7];
      sr   = {sr[6:0], 1'b0};
      repeat (HALF_SCK) @(negedge wCLK24);
      sck = 1'b1;
      repeat (HALF_SCK) @(negedge wCLK24);
      sck = 1'b0;
    end
  endtask

  task automatic send_frame(input int len);
    logic [7:0] b;
    @(negedge wCLK24);
    ss_n = 1'b0;
    // leaves time for the first reply byte to load
    repeat (HALF_SCK) @(negedge wCLK24);
    for (int k = 0; k < len; k++) begin
      next_random_byte(b);
      shift_byte(b);
    end
    repeat (HALF_SCK) @(negedge wCLK24);
    ss_n = 1'b1;
    wait_busy_high();
    wait_busy_low();
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = chk_errors + tb_errors;
  endtask

  task automatic end_test();
    int n;
    n = chk_errors + tb_errors - errors_at_start;
    tests_run++;
    if (n == 0) begin
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, n);
    end
  endtask

  initial begin
    rst_n           = 1'b0;
    sck             = 1'b0;
    ss_n            = 1'b1;
    mosi            = 1'b0;
    lfsr_state      = 16'd59069;
    tb_errors       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    test_name       = "reset";
    repeat (RESET_CYCLES) @(negedge wCLK24);
    rst_n = 1'b1;
    @(negedge wCLK24);

    // first reply comes from the cleared stores
    begin_test("reset_state");
    check_bit("busy_o after reset", 1'b0, busy);
    check_bit("miso_o after reset", 1'b0, miso);
    send_frame(TX_FRAME_BYTES);
    end_test();

    begin_test("full_frame_readback");
    send_frame(RX_FRAME_BYTES);
    end_test();

    begin_test("update_counts");
    send_frame(TX_FRAME_BYTES);
    end_test();

    begin_test("short_frame");
    send_frame(SHORT_BYTES);
    end_test();

    // new bytes 0 to 19, older bytes elsewhere
    begin_test("short_frame_readback");
    send_frame(TX_FRAME_BYTES);
    end_test();

    // reply past byte 77 reads as zero
    begin_test("reply_tail_zero");
    send_frame(LONG_BYTES);
    end_test();

    begin_test("excess_bytes_ignored");
    send_frame(TX_FRAME_BYTES);
    end_test();

    $display("tests %0d, failed %0d, reply bytes checked %0d, errors %0d",
             tests_run, tests_failed, chk_checks, chk_errors + tb_errors);
    if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: tests/tb_checker.sv
// watches the SPI pins like a master, rebuilds each frame and compares the reply bytes
`timescale 1ns/10ps
module tb_checker (
  input  logic  sck_i,
  input  logic  ss_n_i,
  input  logic  mosi_i,
  input  logic  miso_i,
  input  string test_name_i,
  output int    checks_o,
  output int    errors_o
);
  import motor_bridge_pkg::*;

  // kp, ki, kd, setpoint and mode are written once per motor per frame
  localparam int WRITES_PER_FRAME = 5;

  // what the bridge holds from earlier frames
  logic [7:0]            rx_model [RX_FRAME_BYTES] = '{default: 8'h00};
  int                    frames_done = 0;
  int                    check_cnt = 0;
  int                    error_cnt = 0;
  int                    bit_cnt = 0;
  logic [BYTE_IDX_W-1:0] byte_idx = '0;
  logic                  in_frame = 1'b0;
  logic                  ss_n_seen = 1'b1;
  logic [7:0]            mosi_byte = 8'h00;
  logic [7:0]            miso_byte = 8'h00;

  assign checks_o = check_cnt;
  assign errors_o = error_cnt;

  // reply byte the bridge should shift out at this index
  function automatic logic [7:0] expected_reply(input logic [BYTE_IDX_W-1:0] idx);
    logic [15:0]           count;
    logic [BYTE_IDX_W-1:0] offs;
    count = 16'(WRITES_PER_FRAME * frames_done);
    offs  = idx - BYTE_IDX_W'(RX_FRAME_BYTES);
    if (idx < BYTE_IDX_W'(RX_FRAME_BYTES)) begin
      return rx_model[idx];
    end else if (idx < BYTE_IDX_W'(TX_FRAME_BYTES)) begin
      // low byte of each motor's count comes first
      return offs[0] ? count[15:8] : count[7:0];
    end
    return 8'h00;
  endfunction

  task automatic compare_byte(input logic [BYTE_IDX_W-1:0] idx, input logic [7:0] actual);
    logic [7:0] expected;
    expected = expected_reply(idx);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("[FAIL] %s: reply byte %0d expected 0x%02h actual 0x%02h",
               test_name_i, idx, expected, actual);
    end
  endtask

  // master samples both data lines on the rising sck edge
  always @(posedge sck_i or posedge ss_n_i or negedge ss_n_i) begin
    if (ss_n_i !== ss_n_seen) begin
      ss_n_seen = ss_n_i;
      if (ss_n_i === 1'b0) begin
        in_frame = 1'b1;
        bit_cnt  = 0;
        byte_idx = '0;
      end else if (in_frame) begin
        in_frame = 1'b0;
        frames_done++;
      end
    end else if (in_frame && sck_i === 1'b1) begin
      mosi_byte = {mosi_byte[6:0], mosi_i};
      miso_byte = {miso_byte[6:0], miso_i};
      bit_cnt++;
      if (bit_cnt == 8) begin
        compare_byte(byte_idx, miso_byte);
        // later indexes of this frame still see the older bytes
        if (byte_idx < BYTE_IDX_W'(RX_FRAME_BYTES)) begin
          rx_model[byte_idx] = mosi_byte;
        end
        byte_idx = byte_idx + 1'b1;
        bit_cnt  = 0;
      end
    end
  end

endmodule

// File: tests/motor_bridge_asserts.sv
// concurrent checks on the internal bus and the busy flag, bound into the bridge top level
`timescale 1ns/10ps
module motor_bridge_asserts (
  input logic                                    wCLK24,
  input logic                                    rst_n_i,
  input logic                                    busy_i,
  input logic                                    bus_write_i,
  input logic                                    bus_read_i,
  input logic                                    bus_wait_i,
  input logic [motor_bridge_pkg::NUM_MOTORS-1:0] sel_i
);

  logic req;

  assign req = bus_write_i | bus_read_i;

  a_one_strobe: assert property (@(posedge wCLK24) disable iff (!rst_n_i)
    !(bus_write_i && bus_read_i))
    else $error("bus write and bus read high in the same cycle");

  a_sel_onehot: assert property (@(posedge wCLK24) disable iff (!rst_n_i)
    $onehot0(sel_i))
    else $error("more than one channel selected");

  a_busy_reset: assert property (@(posedge wCLK24) $rose(rst_n_i) |-> !busy_i)
    else $error("busy_o high in the first cycle after reset");

  // decoder, channel and mux take one cycle each
  a_req_accept: assert property (@(posedge wCLK24) disable iff (!rst_n_i)
    req |=> bus_wait_i ##1 bus_wait_i ##1 !bus_wait_i)
    else $error("bus request not accepted three cycles after it was issued");

endmodule

bind motor_bridge_top motor_bridge_asserts i_asserts (
  .wCLK24      (wCLK24),
  .rst_n_i     (rst_n_i),
  .busy_i      (busy_o),
  .bus_write_i (bus_write),
  .bus_read_i  (bus_read),
  .bus_wait_i  (bus_wait),
  .sel_i       (ch_sel)
);

// File: source/motor_bridge_top.sv
// motor parameter bridge top level, connects the SPI port, sequencer and motor channels
`timescale 1ns/10ps
module motor_bridge_top (
  input  logic wCLK24,
  input  logic rst_n_i,
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o,
  output logic busy_o
);
  import motor_bridge_pkg::*;

  // SPI side
  logic [BYTE_W-1:0]     rx_byte;
  logic                  rx_valid;
  logic                  frame_start;
  logic                  frame_end;
  logic [BYTE_W-1:0]     tx_byte;
  logic [BYTE_IDX_W-1:0] rx_rd_idx;
  logic [BYTE_W-1:0]     rx_rd_byte;
  logic                  tx_wr_en;
  logic [BYTE_IDX_W-1:0] tx_wr_idx;
  logic [BYTE_W-1:0]     tx_wr_byte;

  // internal bus
  logic [ADDR_W-1:0]     bus_addr;
  logic                  bus_write;
  logic                  bus_read;
  logic [DATA_W-1:0]     bus_wdata;
  logic [DATA_W-1:0]     bus_rdata;
  logic                  bus_wait;

  // channel side
  logic [NUM_MOTORS-1:0]              ch_sel;
  logic [GROUP_W-1:0]                 ch_grp;
  logic                               ch_we;
  logic [DATA_W-1:0]                  ch_wdata;
  logic [NUM_MOTORS-1:0]              ch_ack;
  logic [NUM_MOTORS-1:0][DATA_W-1:0]  ch_rdata;

  spi_byte_port i_spi (
    .wCLK24        (wCLK24),
    .rst_n_i       (rst_n_i),
    .sck_i         (sck_i),
    .ss_n_i        (ss_n_i),
    .mosi_i        (mosi_i),
    .miso_o        (miso_o),
    .tx_byte_i     (tx_byte),
    .rx_byte_o     (rx_byte),
    .rx_valid_o    (rx_valid),
    .frame_start_o (frame_start),
    .frame_end_o   (frame_end)
  );

  frame_buffer i_buf (
    .wCLK24        (wCLK24),
    .rst_n_i       (rst_n_i),
    .rx_byte_i     (rx_byte),
    .rx_valid_i    (rx_valid),
    .frame_start_i (frame_start),
    .rx_rd_idx_i   (rx_rd_idx),
    .rx_rd_byte_o  (rx_rd_byte),
    .tx_wr_en_i    (tx_wr_en),
    .tx_wr_idx_i   (tx_wr_idx),
    .tx_wr_byte_i  (tx_wr_byte),
    .tx_byte_o     (tx_byte)
  );

  param_sequencer i_seq (
    .wCLK24       (wCLK24),
    .rst_n_i      (rst_n_i),
    .frame_end_i  (frame_end),
    .rx_rd_idx_o  (rx_rd_idx),
    .rx_rd_byte_i (rx_rd_byte),
    .tx_wr_en_o   (tx_wr_en),
    .tx_wr_idx_o  (tx_wr_idx),
    .tx_wr_byte_o (tx_wr_byte),
    .bus_addr_o   (bus_addr),
    .bus_write_o  (bus_write),
    .bus_read_o   (bus_read),
    .bus_wdata_o  (bus_wdata),
    .bus_rdata_i  (bus_rdata),
    .bus_wait_i   (bus_wait),
    .busy_o       (busy_o)
  );

  bus_decoder i_dec (
    .wCLK24      (wCLK24),
    .rst_n_i     (rst_n_i),
    .bus_addr_i  (bus_addr),
    .bus_write_i (bus_write),
    .bus_read_i  (bus_read),
    .bus_wdata_i (bus_wdata),
    .sel_o       (ch_sel),
    .grp_o       (ch_grp),
    .we_o        (ch_we),
    .wdata_o     (ch_wdata)
  );

  for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_ch
    motor_channel i_ch (
      .wCLK24  (wCLK24),
      .rst_n_i (rst_n_i),
      .sel_i   (ch_sel[i]),
      .grp_i   (ch_grp),
      .we_i    (ch_we),
      .wdata_i (ch_wdata),
      .ack_o   (ch_ack[i]),
      .rdata_o (ch_rdata[i])
    );
  end

  readback_mux i_mux (
    .wCLK24      (wCLK24),
    .rst_n_i     (rst_n_i),
    .bus_write_i (bus_write),
    .bus_read_i  (bus_read),
    .ack_i       (ch_ack),
    .rdata_i     (ch_rdata),
    .bus_rdata_o (bus_rdata),
    .bus_wait_o  (bus_wait)
  );

endmodule

// File: source/readback_mux.sv
// holds the bus wait request until a channel acks, then registers that channel's read data
`timescale 1ns/10ps
module readback_mux (
  input  logic                                                         wCLK24,
  input  logic                                                         rst_n_i,
  input  logic                                                         bus_write_i,
  input  logic                                                         bus_read_i,
  input  logic [motor_bridge_pkg::NUM_MOTORS-1:0]                      ack_i,
  input  logic [motor_bridge_pkg::NUM_MOTORS-1:0][motor_bridge_pkg::DATA_W-1:0] rdata_i,
  output logic [motor_bridge_pkg::DATA_W-1:0]                          bus_rdata_o,
  output logic                                                         bus_wait_o
);
  import motor_bridge_pkg::*;

  logic [DATA_W-1:0] picked;

  // at most one channel acks at a time
  always_comb begin
    picked = '0;
    for (int i = 0; i < NUM_MOTORS; i++) begin
      if (ack_i[i]) begin
        picked = picked | rdata_i[i];
      end
    end
  end

  always_ff @(posedge wCLK24) begin
    if (!rst_n_i) begin
      bus_wait_o  <= 1'b0;
      bus_rdata_o <= '0;
    end else if (bus_write_i || bus_read_i) begin
      bus_wait_o <= 1'b1;
    end else if (|ack_i) begin
      bus_wait_o  <= 1'b0;
      bus_rdata_o <= picked;
    end
  end

endmodule

// File: source/motor_channel.sv
// one motor's parameter register file with its write counter, answers a select one cycle later
`timescale 1ns/10ps
module motor_channel (
  input  logic                                 wCLK24,
  input  logic                                 rst_n_i,
  input  logic                                 sel_i,
  input  logic [motor_bridge_pkg::GROUP_W-1:0] grp_i,
  input  logic                                 we_i,
  input  logic [motor_bridge_pkg::DATA_W-1:0]  wdata_i,
  output logic                                 ack_o,
  output logic [motor_bridge_pkg::DATA_W-1:0]  rdata_o
);
  import motor_bridge_pkg::*;

  logic [15:0] kp;
  logic [15:0] ki;
  logic [15:0] kd;
  logic [31:0] setpoint;
  logic [7:0]  mode;
  logic [15:0] update_cnt;

  always_ff @(posedge wCLK24) begin
    if (!rst_n_i) begin
      kp         <= '0;
      ki         <= '0;
      kd         <= '0;
      setpoint   <= '0;
      mode       <= '0;
      update_cnt <= '0;
      ack_o      <= 1'b0;
      rdata_o    <= '0;
    end else begin
      ack_o <= sel_i;
      if (sel_i && we_i) begin
        case (grp_i)
          GRP_KP:   kp       <= wdata_i[15:0];
          GRP_KI:   ki       <= wdata_i[15:0];
          GRP_KD:   kd       <= wdata_i[15:0];
          GRP_SP:   setpoint <= wdata_i;
          GRP_MODE: mode     <= wdata_i[7:0];
          default:  ;
        endcase
        // counts every accepted write, wraps at 16 bits
        update_cnt <= update_cnt + 1'b1;
      end
      if (sel_i) begin
        case (grp_i)
          GRP_KP:    rdata_o <= DATA_W'(kp);
          GRP_KI:    rdata_o <= DATA_W'(ki);
          GRP_KD:    rdata_o <= DATA_W'(kd);
          GRP_SP:    rdata_o <= setpoint;
          GRP_MODE:  rdata_o <= DATA_W'(mode);
          GRP_COUNT: rdata_o <= DATA_W'(update_cnt);
          default:   rdata_o <= '0;
        endcase
      end
    end
  end

endmodule

// File: source/bus_decoder.sv
// registers a bus request into a one-hot channel select, register group and write enable
`timescale 1ns/10ps
module bus_decoder (
  input  logic                                    wCLK24,
  input  logic                                    rst_n_i,
  input  logic [motor_bridge_pkg::ADDR_W-1:0]     bus_addr_i,
  input  logic                                    bus_write_i,
  input  logic                                    bus_read_i,
  input  logic [motor_bridge_pkg::DATA_W-1:0]     bus_wdata_i,
  output logic [motor_bridge_pkg::NUM_MOTORS-1:0] sel_o,
  output logic [motor_bridge_pkg::GROUP_W-1:0]    grp_o,
  output logic                                    we_o,
  output logic [motor_bridge_pkg::DATA_W-1:0]     wdata_o
);
  import motor_bridge_pkg::*;

  logic                         req;
  logic [ADDR_W-GROUP_W-1:0]    motor_field;

  assign req         = bus_write_i | bus_read_i;
  assign motor_field = bus_addr_i[ADDR_W-GROUP_W-1:0];

  always_ff @(posedge wCLK24) begin
    if (!rst_n_i) begin
      sel_o   <= '0;
      grp_o   <= '0;
      we_o    <= 1'b0;
      wdata_o <= '0;
    end else begin
      we_o <= bus_write_i;
      // unknown motor numbers fall through with no select
      for (int i = 0; i < NUM_MOTORS; i++) begin
        sel_o[i] <= req && (motor_field == (ADDR_W-GROUP_W)'(i));
      end
      if (req) begin
        grp_o   <= bus_addr_i[ADDR_W-1 -: GROUP_W];
        wdata_o <= bus_wdata_i;
      end
    end
  end

endmodule

// File: source/param_sequencer.sv
// turns a received frame into register writes, then reads the registers back into the reply
`timescale 1ns/10ps
module param_sequencer (
  input  logic                                    wCLK24,
  input  logic                                    rst_n_i,
  input  logic                                    frame_end_i,
  output logic [motor_bridge_pkg::BYTE_IDX_W-1:0] rx_rd_idx_o,
  input  logic [motor_bridge_pkg::BYTE_W-1:0]     rx_rd_byte_i,
  output logic                                    tx_wr_en_o,
  output logic [motor_bridge_pkg::BYTE_IDX_W-1:0] tx_wr_idx_o,
  output logic [motor_bridge_pkg::BYTE_W-1:0]     tx_wr_byte_o,
  output logic [motor_bridge_pkg::ADDR_W-1:0]     bus_addr_o,
  output logic                                    bus_write_o,
  output logic                                    bus_read_o,
  output logic [motor_bridge_pkg::DATA_W-1:0]     bus_wdata_o,
  input  logic [motor_bridge_pkg::DATA_W-1:0]     bus_rdata_i,
  input  logic                                    bus_wait_i,
  output logic                                    busy_o
);
  import motor_bridge_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_GATHER,
    S_WR_WAIT,
    S_RD_REQ,
    S_RD_WAIT,
    S_UNPACK
  } state_t;

  state_t                   state;
  logic [ENTRY_W-1:0]       entry;
  logic [FIELD_LEN_W-2:0]   byte_cnt;
  logic [DATA_W-1:0]        data_q;
  logic [GROUP_W-1:0]       grp;
  logic [MOTOR_IDX_W-1:0]   motor;
  logic [FIELD_LEN_W-1:0]   field_len;
  logic [BYTE_IDX_W-1:0]    byte_idx;
  logic                     last_byte;

  // current field from the package tables
  assign grp       = entry_group(entry);
  assign motor     = entry_motor(entry);
  assign field_len = field_width(grp);
  assign byte_idx  = field_offset(grp, motor) + BYTE_IDX_W'(byte_cnt);
  assign last_byte = ({1'b0, byte_cnt} == field_len - 1'b1);

  assign rx_rd_idx_o  = byte_idx;
  assign tx_wr_idx_o  = byte_idx;
  assign tx_wr_en_o   = (state == S_UNPACK);
  assign tx_wr_byte_o = data_q[byte_cnt*BYTE_W +: BYTE_W];
  assign bus_addr_o   = {grp, (ADDR_W-GROUP_W)'(motor)};
  assign bus_wdata_o  = data_q;
  assign busy_o       = (state != S_IDLE);

  always_ff @(posedge wCLK24) begin
    if (!rst_n_i) begin
      state       <= S_IDLE;
      entry       <= '0;
      byte_cnt    <= '0;
      data_q      <= '0;
      bus_write_o <= 1'b0;
      bus_read_o  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (frame_end_i) begin
            entry    <= '0;
            byte_cnt <= '0;
            data_q   <= '0;
            state    <= S_GATHER;
          end
        end
        // little-endian, one received byte per cycle
        S_GATHER: begin
          data_q[byte_cnt*BYTE_W +: BYTE_W] <= rx_rd_byte_i;
          if (last_byte) begin
            byte_cnt    <= '0;
            bus_write_o <= 1'b1;
            state       <= S_WR_WAIT;
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        // wait is still low in the request cycle itself
        S_WR_WAIT: begin
          bus_write_o <= 1'b0;
          if (!bus_write_o && !bus_wait_i) begin
            data_q <= '0;
            if (entry == ENTRY_W'(NUM_WRITES - 1)) begin
              entry <= '0;
              state <= S_RD_REQ;
            end else begin
              entry <= entry + 1'b1;
              state <= S_GATHER;
            end
          end
        end
        S_RD_REQ: begin
          bus_read_o <= 1'b1;
          state      <= S_RD_WAIT;
        end
        S_RD_WAIT: begin
          bus_read_o <= 1'b0;
          if (!bus_read_o && !bus_wait_i) begin
            data_q <= bus_rdata_i;
            state  <= S_UNPACK;
          end
        end
        S_UNPACK: begin
          if (last_byte) begin
            byte_cnt <= '0;
            if (entry == ENTRY_W'(NUM_READS - 1)) begin
              state <= S_IDLE;
            end else begin
              entry <= entry + 1'b1;
              state <= S_RD_REQ;
            end
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: source/frame_buffer.sv
// byte stores for the received frame and the reply frame, indexed by the SPI byte count
`timescale 1ns/10ps
module frame_buffer (
  input  logic                                    wCLK24,
  input  logic                                    rst_n_i,
  input  logic [motor_bridge_pkg::BYTE_W-1:0]     rx_byte_i,
  input  logic                                    rx_valid_i,
  input  logic                                    frame_start_i,
  input  logic [motor_bridge_pkg::BYTE_IDX_W-1:0] rx_rd_idx_i,
  output logic [motor_bridge_pkg::BYTE_W-1:0]     rx_rd_byte_o,
  input  logic                                    tx_wr_en_i,
  input  logic [motor_bridge_pkg::BYTE_IDX_W-1:0] tx_wr_idx_i,
  input  logic [motor_bridge_pkg::BYTE_W-1:0]     tx_wr_byte_i,
  output logic [motor_bridge_pkg::BYTE_W-1:0]     tx_byte_o
);
  import motor_bridge_pkg::*;

  logic [BYTE_IDX_W-1:0] idx;
  logic [BYTE_W-1:0]     rx_mem [RX_FRAME_BYTES];
  logic [BYTE_W-1:0]     tx_mem [TX_FRAME_BYTES];

  assign rx_rd_byte_o = (rx_rd_idx_i < BYTE_IDX_W'(RX_FRAME_BYTES)) ? rx_mem[rx_rd_idx_i] : '0;
  // past the reply the master clocks out zeros
  assign tx_byte_o    = (idx < BYTE_IDX_W'(TX_FRAME_BYTES)) ? tx_mem[idx] : '0;

  always_ff @(posedge wCLK24) begin
    if (!rst_n_i) begin
      idx <= '0;
      for (int i = 0; i < RX_FRAME_BYTES; i++) begin
        rx_mem[i] <= '0;
      end
      for (int i = 0; i < TX_FRAME_BYTES; i++) begin
        tx_mem[i] <= '0;
      end
    end else begin
      if (frame_start_i) begin
        idx <= '0;
      end else if (rx_valid_i) begin
        if (idx < BYTE_IDX_W'(RX_FRAME_BYTES)) begin
          rx_mem[idx] <= rx_byte_i;
        end
        // saturate so very long frames never wrap back onto the store
        if (idx != '1) begin
          idx <= idx + 1'b1;
        end
      end
      if (tx_wr_en_i && tx_wr_idx_i < BYTE_IDX_W'(TX_FRAME_BYTES)) begin
        tx_mem[tx_wr_idx_i] <= tx_wr_byte_i;
      end
    end
  end

endmodule

// File: source/spi_byte_port.sv
// SPI mode 0 slave on wCLK24, hands whole received bytes on and shifts reply bytes out
`timescale 1ns/10ps
module spi_byte_port (
  input  logic                                wCLK24,
  input  logic                                rst_n_i,
  input  logic                                sck_i,
  input  logic                                ss_n_i,
  input  logic                                mosi_i,
  output logic                                miso_o,
  input  logic [motor_bridge_pkg::BYTE_W-1:0] tx_byte_i,
  output logic [motor_bridge_pkg::BYTE_W-1:0] rx_byte_o,
  output logic                                rx_valid_o,
  output logic                                frame_start_o,
  output logic                                frame_end_o
);
  import motor_bridge_pkg::*;

  // synchroniser bits: 2 sck, 1 ss_n, 0 mosi
  logic [2:0]                  sync_q1;
  logic [2:0]                  sync_q2;
  logic                        sck_prev;
  logic                        ss_n_prev;
  logic [$clog2(BYTE_W)-1:0]   bit_cnt;
  logic [BYTE_W-1:0]           rx_shift;
  logic [BYTE_W-1:0]           tx_shift;
  logic                        load_q;
  logic                        sck_rise;
  logic                        sck_fall;
  logic                        active;

  assign sck_rise = sync_q2[2] & ~sck_prev;
  assign sck_fall = ~sync_q2[2] & sck_prev;
  assign active   = ~sync_q2[1];
  assign miso_o   = tx_shift[BYTE_W-1];

  always_ff @(posedge wCLK24) begin
    if (!rst_n_i) begin
      // ss_n idles high, so no frame edge right out of reset
      sync_q1       <= 3'b010;
      sync_q2       <= 3'b010;
      sck_prev      <= 1'b0;
      ss_n_prev     <= 1'b1;
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
      rx_valid_o    <= 1'b0;
      rx_byte_o     <= '0;
      load_q        <= 1'b0;
      bit_cnt       <= '0;
      rx_shift      <= '0;
      tx_shift      <= '0;
    end else begin
      sync_q1       <= {sck_i, ss_n_i, mosi_i};
      sync_q2       <= sync_q1;
      sck_prev      <= sync_q2[2];
      ss_n_prev     <= sync_q2[1];
      frame_start_o <= ss_n_prev & ~sync_q2[1];
      frame_end_o   <= ~ss_n_prev & sync_q2[1];
      rx_valid_o    <= 1'b0;
      // the buffer index moves one cycle after these, then the reply byte is ready
      load_q        <= frame_start_o | rx_valid_o;

      if (frame_start_o) begin
        bit_cnt <= '0;
      end else if (active && sck_rise) begin
        rx_shift <= {rx_shift[BYTE_W-2:0], sync_q2[0]};
        bit_cnt  <= bit_cnt + 1'b1;
        if (bit_cnt == '1) begin
          rx_valid_o <= 1'b1;
          rx_byte_o  <= {rx_shift[BYTE_W-2:0], sync_q2[0]};
        end
      end

      // no shift on the falling edge after a full byte, the next byte is loaded instead
      if (load_q) begin
        tx_shift <= tx_byte_i;
      end else if (active && sck_fall && bit_cnt != '0) begin
        tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
      end
    end
  end

endmodule

// File: source/motor_bridge_pkg.sv
// shared constants and frame layout tables, imported by every block of the motor bridge
package motor_bridge_pkg;

  localparam int NUM_MOTORS  = 6;
  localparam int MOTOR_IDX_W = 3;
  localparam int GROUP_W     = 8;
  localparam int ADDR_W      = 16;
  localparam int DATA_W      = 32;
  localparam int BYTE_W      = 8;
  localparam int BYTE_IDX_W  = 7;
  localparam int FIELD_LEN_W = 3;

  localparam logic [GROUP_W-1:0] GRP_KP    = 8'd0;
  localparam logic [GROUP_W-1:0] GRP_KI    = 8'd1;
  localparam logic [GROUP_W-1:0] GRP_KD    = 8'd2;
  localparam logic [GROUP_W-1:0] GRP_SP    = 8'd3;
  localparam logic [GROUP_W-1:0] GRP_MODE  = 8'd10;
  localparam logic [GROUP_W-1:0] GRP_COUNT = 8'd15;

  // three 2-byte gains, a 4-byte setpoint and a mode byte per motor
  localparam int RX_FRAME_BYTES = 11 * NUM_MOTORS;
  // reply adds a 2-byte update count per motor
  localparam int TX_FRAME_BYTES = RX_FRAME_BYTES + 2 * NUM_MOTORS;

  localparam int NUM_WRITES = 5 * NUM_MOTORS;
  localparam int NUM_READS  = 6 * NUM_MOTORS;
  localparam int ENTRY_W    = $clog2(NUM_READS);

  // entries run group by group, motor by motor; reads add the count group last
  function automatic logic [GROUP_W-1:0] entry_group(input logic [ENTRY_W-1:0] entry);
    case (int'(entry) / NUM_MOTORS)
      0:       return GRP_KP;
      1:       return GRP_KI;
      2:       return GRP_KD;
      3:       return GRP_SP;
      4:       return GRP_MODE;
      default: return GRP_COUNT;
    endcase
  endfunction

  function automatic logic [MOTOR_IDX_W-1:0] entry_motor(input logic [ENTRY_W-1:0] entry);
    return MOTOR_IDX_W'(int'(entry) % NUM_MOTORS);
  endfunction

  // field length in bytes
  function automatic logic [FIELD_LEN_W-1:0] field_width(input logic [GROUP_W-1:0] grp);
    case (grp)
      GRP_SP:   return 3'd4;
      GRP_MODE: return 3'd1;
      default:  return 3'd2;
    endcase
  endfunction

  // first byte of a field in the frame
  function automatic logic [BYTE_IDX_W-1:0] field_offset(input logic [GROUP_W-1:0] grp,
                                                         input logic [MOTOR_IDX_W-1:0] motor);
    int base;
    case (grp)
      GRP_KP:   base = 0;
      GRP_KI:   base = 2 * NUM_MOTORS;
      GRP_KD:   base = 4 * NUM_MOTORS;
      GRP_SP:   base = 6 * NUM_MOTORS;
      GRP_MODE: base = 10 * NUM_MOTORS;
      default:  base = RX_FRAME_BYTES;
    endcase
    return BYTE_IDX_W'(base + int'(field_width(grp)) * int'(motor));
  endfunction

endpackage
